//--- verilog/ecc_pkg.sv
package ecc_pkg;

  localparam int N_LANES        = 4;
  localparam int DATA_WIDTH     = 64;
  localparam int ECC_WIDTH      = 8;
  localparam int CODE_WIDTH     = 72;
  localparam int BYTES_PER_LANE = 8;
  localparam int WR_BUF_DEPTH   = 4;
  localparam int BUF_PTR_WIDTH  = $clog2(WR_BUF_DEPTH);

  // number of data columns that use the weight-3 patterns.
  localparam int N_W3_COLS = 56;

  typedef logic [DATA_WIDTH-1:0] data_word_t;
  typedef logic [CODE_WIDTH-1:0] code_word_t;
  typedef logic [N_LANES-1:0]    lane_vec_t;

  typedef enum logic [1:0] {
    ECC_OK     = 2'd0,
    ECC_CORR   = 2'd1,
    ECC_UNCORR = 2'd2
  } ecc_status_e;

  // column i of the H matrix.
  // data bits use odd-weight patterns so that every column differs from every
  // one-hot check column and a double error never aliases to a single one.
  function automatic logic [ECC_WIDTH-1:0] ecc_h_col(input int i);
    int                   w3_idx;
    int                   w5_idx;
    logic [ECC_WIDTH-1:0] col;
    logic [ECC_WIDTH-1:0] pat;
    w3_idx = 0;
    w5_idx = 0;
    col    = '0;
    if (i >= DATA_WIDTH) begin
      col[i - DATA_WIDTH] = 1'b1;
    end else begin
      for (int n = 0; n < (1 << ECC_WIDTH); n++) begin
        pat = ECC_WIDTH'(n);
        if ($countones(pat) == 3) begin
          if (w3_idx == i) begin
            col = pat;
          end
          w3_idx++;
        end else if ($countones(pat) == 5) begin
          if (w5_idx + N_W3_COLS == i) begin
            col = pat;
          end
          w5_idx++;
        end
      end
    end
    return col;
  endfunction

  // check bit k is the parity of all data bits whose column has bit k set.
  function automatic logic [ECC_WIDTH-1:0] ecc_check_bits(input data_word_t data);
    logic [ECC_WIDTH-1:0] col;
    logic [ECC_WIDTH-1:0] chk;
    chk = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      col = ecc_h_col(i);
      chk = chk ^ (col & {ECC_WIDTH{data[i]}});
    end
    return chk;
  endfunction

endpackage

//--- verilog/merge_if.sv
interface merge_if;
  import ecc_pkg::*;

  logic                              valid;
  data_word_t [N_LANES-1:0]          wr_data;
  logic [N_LANES*BYTES_PER_LANE-1:0] wr_mask;
  lane_vec_t                         wr_raw;

  // corrected old contents, one lane per entry.
  data_word_t [N_LANES-1:0]          old_data;

  modport wbuf (
    output valid,
    output wr_data,
    output wr_mask,
    output wr_raw
  );

  modport dec (
    output old_data
  );

  modport enc (
    input valid,
    input wr_data,
    input wr_mask,
    input wr_raw,
    input old_data
  );

endinterface

//--- verilog/wr_data_buf.sv
module wr_data_buf (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 wr_valid,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::DATA_WIDTH-1:0]      wr_data,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::BYTES_PER_LANE-1:0]  wr_mask,
  input  ecc_pkg::lane_vec_t                                   wr_raw,
  input  logic                                                 rd_valid,
  output logic                                                 wr_credit,
  merge_if.wbuf                                                merge
);
  import ecc_pkg::*;

  data_word_t [N_LANES-1:0]          data_mem [WR_BUF_DEPTH];
  logic [N_LANES*BYTES_PER_LANE-1:0] mask_mem [WR_BUF_DEPTH];
  lane_vec_t                         raw_mem  [WR_BUF_DEPTH];

  logic [BUF_PTR_WIDTH-1:0] wr_ptr;
  logic [BUF_PTR_WIDTH-1:0] rd_ptr;
  logic [BUF_PTR_WIDTH:0]   fill_cnt;
  logic                     pop_q;
  logic                     push;
  logic                     pop;

  assign push = wr_valid && (fill_cnt != WR_BUF_DEPTH);

  // the read was accepted one cycle earlier, so the pop lands in the same
  // cycle as the decoder's registered output.
  assign pop = pop_q && (fill_cnt != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= wr_data;
      mask_mem[wr_ptr] <= wr_mask;
      raw_mem[wr_ptr]  <= wr_raw;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_q    <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      pop_q <= rd_valid;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // each released entry hands one credit back to the host.
  assign wr_credit = pop;

  assign merge.valid   = pop;
  assign merge.wr_data = data_mem[rd_ptr];
  assign merge.wr_mask = mask_mem[rd_ptr];
  assign merge.wr_raw  = raw_mem[rd_ptr];

endmodule

//--- verilog/ecc_dec_fix.sv
module ecc_dec_fix (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             rd_valid,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::CODE_WIDTH-1:0]  rd_data,
  output logic                                             rd_status_valid,
  output ecc_pkg::lane_vec_t                               rd_corr,
  output ecc_pkg::lane_vec_t                               rd_uncorr,
  merge_if.dec                                             merge
);
  import ecc_pkg::*;

  data_word_t [N_LANES-1:0] fixed_data;
  data_word_t [N_LANES-1:0] old_data_q;
  lane_vec_t                lane_corr;
  lane_vec_t                lane_uncorr;
  lane_vec_t                corr_q;
  lane_vec_t                uncorr_q;
  logic                     status_valid_q;

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    code_word_t           code;
    logic [ECC_WIDTH-1:0] syndrome;
    logic [CODE_WIDTH-1:0] flip;
    ecc_status_e          status;

    assign code     = rd_data[l*CODE_WIDTH +: CODE_WIDTH];
    assign syndrome = ecc_check_bits(code[DATA_WIDTH-1:0]) ^
                      code[CODE_WIDTH-1:DATA_WIDTH];

    // no column is zero, so a clean word never matches.
    always_comb begin
      flip = '0;
      for (int i = 0; i < CODE_WIDTH; i++) begin
        if (syndrome == ecc_h_col(i)) begin
          flip[i] = 1'b1;
        end
      end
    end

    always_comb begin
      if (syndrome == '0) begin
        status = ECC_OK;
      end else if (|flip) begin
        status = ECC_CORR;
      end else begin
        status = ECC_UNCORR;
      end
    end

    // a hit on a check column leaves the data as it is.
    assign fixed_data[l]  = code[DATA_WIDTH-1:0] ^ flip[DATA_WIDTH-1:0];
    assign lane_corr[l]   = (status == ECC_CORR);
    assign lane_uncorr[l] = (status == ECC_UNCORR);
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      old_data_q <= fixed_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_valid_q <= 1'b0;
      corr_q         <= '0;
      uncorr_q       <= '0;
    end else begin
      status_valid_q <= rd_valid;
      corr_q         <= rd_valid ? lane_corr : '0;
      uncorr_q       <= rd_valid ? lane_uncorr : '0;
    end
  end

  assign rd_status_valid = status_valid_q;
  assign rd_corr         = corr_q;
  assign rd_uncorr       = uncorr_q;
  assign merge.old_data  = old_data_q;

endmodule

//--- verilog/ecc_merge_enc.sv
module ecc_merge_enc (
  input  logic                                             clk,
  input  logic                                             rst_n,
  merge_if.enc                                             merge,
  output logic                                             mc_wrdata_valid,
  output logic [ecc_pkg::N_LANES*ecc_pkg::CODE_WIDTH-1:0]  mc_wrdata
);
  import ecc_pkg::*;

  logic                              valid_q;
  data_word_t [N_LANES-1:0]          wr_data_q;
  data_word_t [N_LANES-1:0]          old_data_q;
  logic [N_LANES*BYTES_PER_LANE-1:0] wr_mask_q;
  lane_vec_t                         raw_q;
  data_word_t [N_LANES-1:0]          merged;
  code_word_t [N_LANES-1:0]          code_c;
  logic                              out_valid_q;

  always_ff @(posedge clk) begin
    wr_data_q  <= merge.wr_data;
    old_data_q <= merge.old_data;
    wr_mask_q  <= merge.wr_mask;
    raw_q      <= merge.wr_raw;
  end

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    logic [ECC_WIDTH-1:0] chk;

    // a set mask bit keeps the byte that is already in memory.
    for (genvar b = 0; b < BYTES_PER_LANE; b++) begin : g_byte
      assign merged[l][b*8 +: 8] = wr_mask_q[l*BYTES_PER_LANE + b] ?
                                   old_data_q[l][b*8 +: 8] :
                                   wr_data_q[l][b*8 +: 8];
    end

    assign chk       = raw_q[l] ? '0 : ecc_check_bits(merged[l]);
    assign code_c[l] = {chk, merged[l]};
  end

  always_ff @(posedge clk) begin
    mc_wrdata <= code_c;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      valid_q     <= merge.valid;
      out_valid_q <= valid_q;
    end
  end

  assign mc_wrdata_valid = out_valid_q;

endmodule

//--- verilog/ecc_wr_path.sv
module ecc_wr_path (
  input  logic                                                 clk,
  input  logic                                                 rst_n,

  input  logic                                                 wr_valid,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::DATA_WIDTH-1:0]      wr_data,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::BYTES_PER_LANE-1:0]  wr_mask,
  input  ecc_pkg::lane_vec_t                                   wr_raw,
  output logic                                                 wr_credit,

  input  logic                                                 rd_valid,
  input  logic [ecc_pkg::N_LANES*ecc_pkg::CODE_WIDTH-1:0]      rd_data,

  output logic                                                 mc_wrdata_valid,
  output logic [ecc_pkg::N_LANES*ecc_pkg::CODE_WIDTH-1:0]      mc_wrdata,

  output logic                                                 rd_status_valid,
  output ecc_pkg::lane_vec_t                                   rd_corr,
  output ecc_pkg::lane_vec_t                                   rd_uncorr
);

  merge_if merge_bus ();

  wr_data_buf u_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_valid  (wr_valid),
    .wr_data   (wr_data),
    .wr_mask   (wr_mask),
    .wr_raw    (wr_raw),
    .rd_valid  (rd_valid),
    .wr_credit (wr_credit),
    .merge     (merge_bus.wbuf)
  );

  ecc_dec_fix u_dec (
    .clk             (clk),
    .rst_n           (rst_n),
    .rd_valid        (rd_valid),
    .rd_data         (rd_data),
    .rd_status_valid (rd_status_valid),
    .rd_corr         (rd_corr),
    .rd_uncorr       (rd_uncorr),
    .merge           (merge_bus.dec)
  );

  ecc_merge_enc u_enc (
    .clk             (clk),
    .rst_n           (rst_n),
    .merge           (merge_bus.enc),
    .mc_wrdata_valid (mc_wrdata_valid),
    .mc_wrdata       (mc_wrdata)
  );

endmodule

//--- dv/ecc_checker.sv
module ecc_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               wr_valid,
  input logic               rd_valid,
  input logic               mc_wrdata_valid,
  input ecc_pkg::lane_vec_t rd_corr,
  input ecc_pkg::lane_vec_t rd_uncorr
);
  timeunit 1ns;
  timeprecision 1ps;
  import ecc_pkg::*;

  // writes that are stored and still wait for their read data.
  logic [BUF_PTR_WIDTH:0] pending;

  int n_empty_rd = 0;
  int n_latency  = 0;
  int n_flags    = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending + {{BUF_PTR_WIDTH{1'b0}}, wr_valid} -
                 {{BUF_PTR_WIDTH{1'b0}}, rd_valid};
    end
  end

  a_rd_not_empty: assert property (
    @(posedge clk) disable iff (!rst_n) rd_valid |-> (pending != '0)
  ) else begin
    n_empty_rd++;
    $error("read data arrived while no write was waiting in the buffer");
  end

  // the merged word leaves three cycles after its read, and never otherwise.
  a_out_latency: assert property (
    @(posedge clk) disable iff (!rst_n) mc_wrdata_valid == $past(rd_valid, 3)
  ) else begin
    n_latency++;
    $error("write data valid does not follow read valid by three cycles");
  end

  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) (rd_corr & rd_uncorr) == '0
  ) else begin
    n_flags++;
    $error("a lane reports a corrected and an uncorrectable error together");
  end

endmodule

bind ecc_wr_path ecc_checker u_checker (
  .clk             (clk),
  .rst_n           (rst_n),
  .wr_valid        (wr_valid),
  .rd_valid        (rd_valid),
  .mc_wrdata_valid (mc_wrdata_valid),
  .rd_corr         (rd_corr),
  .rd_uncorr       (rd_uncorr)
);

//--- dv/ecc_tb.sv
module ecc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ecc_pkg::*;

  logic                              clk;
  logic                              rst_n;
  logic                              wr_valid;
  logic [N_LANES*DATA_WIDTH-1:0]     wr_data;
  logic [N_LANES*BYTES_PER_LANE-1:0] wr_mask;
  lane_vec_t                         wr_raw;
  logic                              wr_credit;
  logic                              rd_valid;
  logic [N_LANES*CODE_WIDTH-1:0]     rd_data;
  logic                              mc_wrdata_valid;
  logic [N_LANES*CODE_WIDTH-1:0]     mc_wrdata;
  logic                              rd_status_valid;
  lane_vec_t                         rd_corr;
  lane_vec_t                         rd_uncorr;

  // one entry per stimulus line, kept in file order.
  logic [N_LANES*DATA_WIDTH-1:0]     txn_wdata [$];
  logic [N_LANES*BYTES_PER_LANE-1:0] txn_mask [$];
  lane_vec_t                         txn_raw [$];
  logic [N_LANES*CODE_WIDTH-1:0]     txn_rd [$];
  logic [N_LANES*CODE_WIDTH-1:0]     exp_word [$];
  lane_vec_t                         exp_corr [$];
  lane_vec_t                         exp_uncorr [$];

  int n_txn      = 0;
  int credits    = WR_BUF_DEPTH;
  int n_words    = 0;
  int n_status   = 0;
  int n_mismatch = 0;
  int n_other    = 0;
  bit loaded     = 1'b0;

  ecc_wr_path UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic code_word_t encode_lane(data_word_t d, logic raw);
    logic [ECC_WIDTH-1:0] chk;
    chk = raw ? '0 : ecc_check_bits(d);
    return {chk, d};
  endfunction

  task automatic check_code_word(string name, code_word_t exp, code_word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic check_flags(string name, lane_vec_t exp, lane_vec_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic load_stimulus();
    int                                fd;
    int                                rc;
    int                                flip [3];
    int                                nflip [N_LANES];
    logic [N_LANES*DATA_WIDTH-1:0]     wd;
    logic [N_LANES*DATA_WIDTH-1:0]     od;
    logic [N_LANES*BYTES_PER_LANE-1:0] m;
    lane_vec_t                         raw;
    logic [N_LANES*CODE_WIDTH-1:0]     rd;
    logic [N_LANES*CODE_WIDTH-1:0]     word;
    lane_vec_t                         corr;
    lane_vec_t                         uncorr;
    data_word_t                        base;
    data_word_t                        merged;
    fd = $fopen("dv/ecc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file dv/ecc_stimulus.txt");
      n_other++;
      return;
    end
    rc = $fscanf(fd, "%h %h %h %h %d %d %d\n", wd, m, raw, od, flip[0], flip[1], flip[2]);
    while (rc == 7) begin
      for (int l = 0; l < N_LANES; l++) begin
        rd[l*CODE_WIDTH +: CODE_WIDTH] = encode_lane(od[l*DATA_WIDTH +: DATA_WIDTH], 1'b0);
        nflip[l] = 0;
      end
      // a position past the end of the word means no flip.
      for (int k = 0; k < 3; k++) begin
        if (flip[k] < N_LANES*CODE_WIDTH) begin
          rd[flip[k]] = ~rd[flip[k]];
          nflip[flip[k] / CODE_WIDTH]++;
        end
      end
      for (int l = 0; l < N_LANES; l++) begin
        // one flip gets corrected, two leave the read data as it arrived.
        base = (nflip[l] > 1) ? rd[l*CODE_WIDTH +: DATA_WIDTH] : od[l*DATA_WIDTH +: DATA_WIDTH];
        for (int b = 0; b < BYTES_PER_LANE; b++) begin
          merged[b*8 +: 8] = m[l*BYTES_PER_LANE + b] ? base[b*8 +: 8] :
                             wd[l*DATA_WIDTH + b*8 +: 8];
        end
        word[l*CODE_WIDTH +: CODE_WIDTH] = encode_lane(merged, raw[l]);
        corr[l]   = (nflip[l] == 1);
        uncorr[l] = (nflip[l] > 1);
      end
      txn_wdata.push_back(wd);
      txn_mask.push_back(m);
      txn_raw.push_back(raw);
      txn_rd.push_back(rd);
      exp_word.push_back(word);
      exp_corr.push_back(corr);
      exp_uncorr.push_back(uncorr);
      n_txn++;
      rc = $fscanf(fd, "%h %h %h %h %d %d %d\n", wd, m, raw, od, flip[0], flip[1], flip[2]);
    end
    $fclose(fd);
    if (n_txn == 0) begin
      $display("ERROR: the stimulus file holds no transactions");
      n_other++;
    end
  endtask

  task automatic sample_outputs();
    logic [N_LANES*CODE_WIDTH-1:0] word;
    if (wr_credit) begin
      credits++;
    end
    if (credits < 0 || credits > WR_BUF_DEPTH) begin
      $display("ERROR: host credit count left its range, now %0d", credits);
      n_other++;
    end
    if (rd_status_valid) begin
      if (exp_corr.size() == 0) begin
        $display("ERROR: read status appeared with no read outstanding");
        n_other++;
      end else begin
        check_flags($sformatf("txn %0d rd_corr", n_status), exp_corr.pop_front(), rd_corr);
        check_flags($sformatf("txn %0d rd_uncorr", n_status), exp_uncorr.pop_front(),
                    rd_uncorr);
      end
      n_status++;
    end
    if (mc_wrdata_valid) begin
      if (exp_word.size() == 0) begin
        $display("ERROR: merged write data appeared with no read outstanding");
        n_other++;
      end else begin
        word = exp_word.pop_front();
        for (int l = 0; l < N_LANES; l++) begin
          check_code_word($sformatf("txn %0d lane %0d", n_words, l),
                          word[l*CODE_WIDTH +: CODE_WIDTH], mc_wrdata[l*CODE_WIDTH +: CODE_WIDTH]);
        end
      end
      n_words++;
    end
  endtask

  // outputs settle after the rising edge, so they are read at the falling one.
  task automatic next_cycle();
    @(negedge clk);
    sample_outputs();
    wr_valid = 1'b0;
    rd_valid = 1'b0;
  endtask

  task automatic issue_write(int idx);
    while (credits == 0) begin
      next_cycle();
    end
    wr_valid = 1'b1;
    wr_data  = txn_wdata[idx];
    wr_mask  = txn_mask[idx];
    wr_raw   = txn_raw[idx];
    credits--;
    next_cycle();
  endtask

  task automatic issue_read(int idx);
    rd_valid = 1'b1;
    rd_data  = txn_rd[idx];
    next_cycle();
  endtask

  initial begin
    wait (loaded);
    repeat (20 * n_txn + 100) @(posedge clk);
    $display("ERROR: watchdog expired before all writes left the pipeline");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int n_burst;
    int n_assert;
    void'($urandom(32'h18fe_e972));
    rst_n    = 1'b0;
    wr_valid = 1'b0;
    wr_data  = '0;
    wr_mask  = '0;
    wr_raw   = '0;
    rd_valid = 1'b0;
    rd_data  = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // the first writes fill the buffer, then their reads follow back to back.
    n_burst = (n_txn < WR_BUF_DEPTH) ? n_txn : WR_BUF_DEPTH;
    for (int i = 0; i < n_burst; i++) begin
      issue_write(i);
    end
    for (int i = 0; i < n_burst; i++) begin
      issue_read(i);
    end
    for (int i = n_burst; i < n_txn; i++) begin
      issue_write(i);
      repeat ($urandom_range(3, 0)) next_cycle();
      issue_read(i);
    end
    while (exp_word.size() != 0 || exp_corr.size() != 0) begin
      next_cycle();
    end
    if (credits != WR_BUF_DEPTH) begin
      $display("ERROR: host holds %0d credits at the end, expected %0d", credits, WR_BUF_DEPTH);
      n_other++;
    end
    n_assert = UUT.u_checker.n_empty_rd + UUT.u_checker.n_latency + UUT.u_checker.n_flags;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             n_mismatch, n_other, n_assert);
    if (n_mismatch + n_other + n_assert == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- dv/ecc_stimulus.txt
0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 ffffffff 0 a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5adeadbeefcafef00d1122334455667788 999 999 999
a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5adeadbeefcafef00d1122334455667788 00000000 0 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 999 999 999
13579bdf02468acec001d00dfeedface77778888999900000badc0de8badf00d 0f0f33a5 0 31415926535897932718281828459045ffffffffffffffff0000000000000000 999 999 999
ffffffffffffffff0000000000000000ffffffffffffffff0000000000000000 55aa00ff 5 0f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a 999 999 999
314159265358979327182818284590450123456789abcdeffedcba9876543210 ffffffff 0 deadbeefcafef00d112233445566778813579bdf02468acec001d00dfeedface 3 210 999
0123456789abcdef0123456789abcdeffedcba9876543210fedcba9876543210 0000ffff 0 77778888999900000badc0de8badf00d31415926535897932718281828459045 77 112 286
0f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a 12345678 f 1122334455667788deadbeefcafef00d5a5a5a5a5a5a5a5aa5a5a5a5a5a5a5a5 999 999 999
271828182845904531415926535897930badc0de8badf00d7777888899990000 ffffffff 0 c001d00dfeedface13579bdf02468ace0000000000000000ffffffffffffffff 0 71 999
0000000000000000000000000000000000000000000000000000000000000000 00ff00ff 2 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 100 150 999
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff a5a5a5a5 0 0000000000000000000000000000000000000000000000000000000000000000 999 999 999
deadbeefcafef00d11223344556677880123456789abcdeffedcba9876543210 ffffffff 8 0f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a 63 135 200
13579bdf02468ace13579bdf02468acec001d00dfeedfacec001d00dfeedface 0f0f0f0f 0 777788889999000077778888999900000badc0de8badf00d0badc0de8badf00d 216 217 143
0badc0de8badf00d314159265358979327182818284590450123456789abcdef 3c3c3c3c 3 fedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0a5a5a5a5a5a5a5a5 64 999 999
5a5a5a5a5a5a5a5aa5a5a5a5a5a5a5a58796a5b4c3d2e1f00f1e2d3c4b5a6978 ffffffff 0 271828182845904531415926535897930badc0de8badf00d7777888899990000 10 20 999
8796a5b4c3d2e1f00f1e2d3c4b5a6978fedcba98765432100123456789abcdef 00000000 0 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 5 80 160
11223344556677881122334455667788deadbeefcafef00ddeadbeefcafef00d f0f0f0f0 6 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 287 999 999
c001d00dfeedface77778888999900000badc0de8badf00d3141592653589793 0000ffff 0 13579bdf02468acec001d00dfeedface77778888999900000badc0de8badf00d 144 215 999
0123456789abcdefa5a5a5a5a5a5a5a5ffffffffffffffff7777888899990000 ffffffff 0 fedcba98765432105a5a5a5a5a5a5a5a00000000000000000badc0de8badf00d 30 102 174
0f1e2d3c4b5a6978deadbeefcafef00d13579bdf02468ace3141592653589793 96969696 9 8796a5b4c3d2e1f01122334455667788c001d00dfeedface2718281828459045 250 999 999
fedcba98765432108796a5b4c3d2e1f05a5a5a5a5a5a5a5a1122334455667788 ffffffff 0 0123456789abcdef0f1e2d3c4b5a6978a5a5a5a5a5a5a5a5deadbeefcafef00d 999 999 999

//--- sources.f
verilog/ecc_pkg.sv
verilog/merge_if.sv
verilog/wr_data_buf.sv
verilog/ecc_dec_fix.sv
verilog/ecc_merge_enc.sv
verilog/ecc_wr_path.sv
dv/ecc_checker.sv
dv/ecc_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := ecc_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
RUN_OPTS  := +verilator+error+limit+1000
PASS_MSG  := Result: PASSED

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_OPTS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
